/* rtl/bitplane_shifter.sv */
//////////////////////////////////////////////////////////////////////
// Six bitplane data registers and shifters, one pixel per clk
// A BPL1DAT write reloads all shifters, other planes from storage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module bitplane_shifter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  denise_pkg::bpl_wr_t      bpl_wr,
  input  denise_pkg::pf_ctrl_t     pf_ctrl,
  output denise_pkg::plane_bits_t  plane_bits
);

  logic [denise_pkg::PLANE_W-1:0] bpl_dat  [denise_pkg::NUM_PLANES];
  logic [denise_pkg::PLANE_W-1:0] dat_next [denise_pkg::NUM_PLANES];
  logic [denise_pkg::PLANE_W-1:0] shift_q  [denise_pkg::NUM_PLANES];
  logic                           load;
  logic [denise_pkg::NUM_PLANES-1:0] plane_en;

  // Plane 1 write triggers the parallel load
  assign load = bpl_wr.valid && (bpl_wr.plane == 3'd0);

  // Incoming write bypasses its data register
  always_comb begin
    for (int i = 0; i < denise_pkg::NUM_PLANES; i++) begin
      if (bpl_wr.valid && (bpl_wr.plane == 3'(i))) begin
        dat_next[i] = bpl_wr.data;
      end else begin
        dat_next[i] = bpl_dat[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data registers and shifters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < denise_pkg::NUM_PLANES; i++) begin
        bpl_dat[i] <= '0;
        shift_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < denise_pkg::NUM_PLANES; i++) begin
        bpl_dat[i] <= dat_next[i];
        if (load) begin
          shift_q[i] <= dat_next[i];
        end else begin
          // MSB first, zero fill once the word is out
          shift_q[i] <= {shift_q[i][denise_pkg::PLANE_W-2:0], 1'b0};
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Plane enables
  //////////////////////////////////////////////////////////////////////

  // Planes at or above the count are forced to zero
  always_comb begin
    for (int i = 0; i < denise_pkg::NUM_PLANES; i++) begin
      plane_en[i]   = (pf_ctrl.bpu > 3'(i));
      plane_bits[i] = shift_q[i][denise_pkg::PLANE_W-1] & plane_en[i];
    end
  end

  // Decoder clamp keeps the count within the plane set
  a_bpu_range : assert property (@(posedge clk) disable iff (!rst_n)
    pf_ctrl.bpu <= 3'(denise_pkg::NUM_PLANES));

endmodule

/* rtl/colour_table.sv */
//////////////////////////////////////////////////////////////////////
// 32 x 12-bit colour table, one write port, registered read
// Contents are undefined until written
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module colour_table (
  input  logic                  clk,
  input  denise_pkg::clut_wr_t  clut_wr,
  input  denise_pkg::pix_code_u pix_code,
  output denise_pkg::rgb_t      colour,
  output denise_pkg::pix_code_u pix_code_d
);

  denise_pkg::rgb_t mem [denise_pkg::NUM_COLOURS];
  logic [4:0]       rd_idx;

  // A HAM select code has op 00, so idx[4] is clear
  // and the read lands on the 4-bit value
  assign rd_idx = pix_code.col.idx;

  // Register writes
  always_ff @(posedge clk) begin
    if (clut_wr.valid) begin
      mem[clut_wr.idx] <= clut_wr.colour;
    end
  end

  // Colour and code leave together
  always_ff @(posedge clk) begin
    colour     <= mem[rd_idx];
    pix_code_d <= pix_code;
  end

endmodule

/* rtl/denise_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types and constants for the playfield video path
// Register addresses are word addresses (byte address >> 1)
//////////////////////////////////////////////////////////////////////

package denise_pkg;

  // Sizes
  localparam int NUM_PLANES    = 6;
  localparam int PLANE_W       = 16;
  localparam int NUM_COLOURS   = 32;
  localparam int PIXEL_LATENCY = 4;

  // Register word addresses
  localparam logic [7:0] BPLCON0_ADDR = 8'h80;  // $100
  localparam logic [7:0] BPLCON2_ADDR = 8'h82;  // $104
  localparam logic [7:0] BPL1DAT_ADDR = 8'h88;  // $110, block of eight words
  localparam logic [7:0] COLOR00_ADDR = 8'hC0;  // $180, block of 32 words

  // Control register bit positions
  localparam int CON0_BPU_LSB    = 12;
  localparam int CON0_HOMOD_BIT  = 11;
  localparam int CON0_DBLPF_BIT  = 10;
  localparam int CON2_PF2PRI_BIT = 6;

  // Playfield 2 uses the upper half of the first 16 colours
  localparam int PF2_COLOUR_BASE = 8;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  typedef struct packed {
    logic        valid;
    logic [7:0]  addr;
    logic [15:0] data;
  } reg_wr_t;

  typedef struct packed {
    logic               valid;
    logic [2:0]         plane;
    logic [PLANE_W-1:0] data;
  } bpl_wr_t;

  typedef struct packed {
    logic       valid;
    logic [4:0] idx;
    rgb_t       colour;
  } clut_wr_t;

  typedef struct packed {
    logic [2:0] bpu;     // Planes in use, 0 to 6
    logic       ham;
    logic       dblpf;
    logic       pf2pri;  // Playfield 2 in front
  } pf_ctrl_t;

  // Bit 0 is plane 1
  typedef logic [NUM_PLANES-1:0] plane_bits_t;

  // Normal and half-brite view
  typedef struct packed {
    logic       ehb;
    logic [4:0] idx;
  } pix_col_t;

  // Hold-and-modify view
  typedef struct packed {
    logic [1:0] op;
    logic [3:0] val;
  } pix_ham_t;

  typedef union packed {
    pix_col_t col;
    pix_ham_t ham;
  } pix_code_u;

endpackage

/* rtl/denise_top.sv */
//////////////////////////////////////////////////////////////////////
// Playfield video path, one clk per pixel
// First pixel of a BPL1DAT load appears PIXEL_LATENCY clocks later
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module denise_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  denise_pkg::reg_wr_t  bus,
  output denise_pkg::rgb_t     rgb
);

  denise_pkg::bpl_wr_t     bpl_wr;
  denise_pkg::clut_wr_t    clut_wr;
  denise_pkg::pf_ctrl_t    pf_ctrl;
  denise_pkg::plane_bits_t plane_bits;
  denise_pkg::pix_code_u   pix_code;
  denise_pkg::pix_code_u   pix_code_d;
  denise_pkg::rgb_t        colour;

  // Stage 1, bus decode and control
  reg_decoder u_reg_decoder (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus     (bus),
    .bpl_wr  (bpl_wr),
    .clut_wr (clut_wr),
    .pf_ctrl (pf_ctrl)
  );

  // Stage 2, shifters
  bitplane_shifter u_bitplane_shifter (
    .clk        (clk),
    .rst_n      (rst_n),
    .bpl_wr     (bpl_wr),
    .pf_ctrl    (pf_ctrl),
    .plane_bits (plane_bits)
  );

  // Stage 3, pixel code
  playfield_priority u_playfield_priority (
    .clk        (clk),
    .rst_n      (rst_n),
    .plane_bits (plane_bits),
    .pf_ctrl    (pf_ctrl),
    .pix_code   (pix_code)
  );

  // Stage 4, colour lookup
  colour_table u_colour_table (
    .clk        (clk),
    .clut_wr    (clut_wr),
    .pix_code   (pix_code),
    .colour     (colour),
    .pix_code_d (pix_code_d)
  );

  // Stage 5, EHB and HAM
  pixel_output u_pixel_output (
    .clk        (clk),
    .rst_n      (rst_n),
    .colour     (colour),
    .pix_code_d (pix_code_d),
    .pf_ctrl    (pf_ctrl),
    .rgb        (rgb)
  );

endmodule

/* rtl/pixel_output.sv */
//////////////////////////////////////////////////////////////////////
// Final pixel stage with extra-half-brite and hold-and-modify
// HAM holds the previous output pixel, no line start reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pixel_output (
  input  logic                  clk,
  input  logic                  rst_n,
  input  denise_pkg::rgb_t      colour,
  input  denise_pkg::pix_code_u pix_code_d,
  input  denise_pkg::pf_ctrl_t  pf_ctrl,
  output denise_pkg::rgb_t      rgb
);

  denise_pkg::rgb_t rgb_n;

  //////////////////////////////////////////////////////////////////////
  // Colour modes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rgb_n = colour;
    if (pf_ctrl.ham) begin
      // Start from the held pixel
      rgb_n = rgb;
      case (pix_code_d.ham.op)
        2'd0: rgb_n   = colour;
        2'd1: rgb_n.b = pix_code_d.ham.val;
        2'd2: rgb_n.r = pix_code_d.ham.val;
        2'd3: rgb_n.g = pix_code_d.ham.val;
        default: rgb_n = colour;
      endcase
    end else if (pix_code_d.col.ehb) begin
      // Half brightness, each component down one bit
      rgb_n.r = {1'b0, colour.r[3:1]};
      rgb_n.g = {1'b0, colour.g[3:1]};
      rgb_n.b = {1'b0, colour.b[3:1]};
    end
  end

  // Output register, also the HAM hold register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rgb <= '0;
    end else begin
      rgb <= rgb_n;
    end
  end

  // Needs every colour entry in use written before display
  a_rgb_known : assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(rgb));

endmodule

/* rtl/playfield_priority.sv */
//////////////////////////////////////////////////////////////////////
// Single and dual playfield selection into a registered pixel code
// No sprites, so no playfield priority numbers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module playfield_priority (
  input  logic                     clk,
  input  logic                     rst_n,
  input  denise_pkg::plane_bits_t  plane_bits,
  input  denise_pkg::pf_ctrl_t     pf_ctrl,
  output denise_pkg::pix_code_u    pix_code
);

  logic [2:0]            pf1;
  logic [2:0]            pf2;
  logic                  pf1_on;
  logic                  pf2_on;
  logic                  pf2_front;
  denise_pkg::pix_code_u code_n;

  //////////////////////////////////////////////////////////////////////
  // Dual playfield split
  //////////////////////////////////////////////////////////////////////

  // Odd planes form playfield 1, even planes playfield 2
  always_comb begin
    pf1    = {plane_bits[4], plane_bits[2], plane_bits[0]};
    pf2    = {plane_bits[5], plane_bits[3], plane_bits[1]};
    pf1_on = |pf1;
    pf2_on = |pf2;
    // Playfield 2 shows alone, or in front when PF2PRI is set
    pf2_front = pf2_on && (!pf1_on || pf_ctrl.pf2pri);
  end

  //////////////////////////////////////////////////////////////////////
  // Code selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    code_n = '0;
    if (pf_ctrl.dblpf) begin
      // No half-brite in dual playfield
      code_n.col.ehb = 1'b0;
      if (pf2_front) begin
        code_n.col.idx = 5'(denise_pkg::PF2_COLOUR_BASE) + {2'b00, pf2};
      end else begin
        // Also covers both playfields transparent
        code_n.col.idx = {2'b00, pf1};
      end
    end else if (pf_ctrl.ham) begin
      // Planes 5 and 6 carry the operation
      code_n.ham.op  = plane_bits[5:4];
      code_n.ham.val = plane_bits[3:0];
    end else begin
      // Plane 6 doubles as the half-brite flag
      code_n.col.ehb = plane_bits[5];
      code_n.col.idx = plane_bits[4:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_code <= '0;
    end else begin
      pix_code <= code_n;
    end
  end

endmodule

/* rtl/reg_decoder.sv */
//////////////////////////////////////////////////////////////////////
// Write-only register bus, one write per cycle, no back-pressure
// Only BPLCON0, BPLCON2, BPLxDAT and COLORxx are decoded
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module reg_decoder (
  input  logic                  clk,
  input  logic                  rst_n,
  input  denise_pkg::reg_wr_t   bus,
  output denise_pkg::bpl_wr_t   bpl_wr,
  output denise_pkg::clut_wr_t  clut_wr,
  output denise_pkg::pf_ctrl_t  pf_ctrl
);

  denise_pkg::reg_wr_t bus_q;
  logic                bpl_hit;
  logic                clut_hit;
  logic                con0_hit;
  logic                con2_hit;
  logic [2:0]          bpu_raw;
  logic [2:0]          bpu_clamped;

  // Bus stage, one cycle ahead of every consumer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_q <= '0;
    end else begin
      bus_q <= bus;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Address compare
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    bpl_hit  = bus_q.valid && (bus_q.addr[7:3] == denise_pkg::BPL1DAT_ADDR[7:3]);
    clut_hit = bus_q.valid && (bus_q.addr[7:5] == denise_pkg::COLOR00_ADDR[7:5]);
    con0_hit = bus_q.valid && (bus_q.addr == denise_pkg::BPLCON0_ADDR);
    con2_hit = bus_q.valid && (bus_q.addr == denise_pkg::BPLCON2_ADDR);
  end

  // Bitplane data write, plane number from the low address bits
  always_comb begin
    bpl_wr.valid = bpl_hit;
    bpl_wr.plane = bus_q.addr[2:0];
    bpl_wr.data  = bus_q.data;
  end

  // Colour write, 12-bit colour in the low data bits
  always_comb begin
    clut_wr.valid  = clut_hit;
    clut_wr.idx    = bus_q.addr[4:0];
    clut_wr.colour = bus_q.data[11:0];
  end

  //////////////////////////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////////////////////////

  // Plane count 7 is not a valid mode here
  assign bpu_raw     = bus_q.data[denise_pkg::CON0_BPU_LSB +: 3];
  assign bpu_clamped = (bpu_raw > 3'(denise_pkg::NUM_PLANES)) ?
                       3'(denise_pkg::NUM_PLANES) : bpu_raw;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pf_ctrl <= '0;
    end else begin
      if (con0_hit) begin
        pf_ctrl.bpu   <= bpu_clamped;
        pf_ctrl.ham   <= bus_q.data[denise_pkg::CON0_HOMOD_BIT];
        pf_ctrl.dblpf <= bus_q.data[denise_pkg::CON0_DBLPF_BIT];
      end
      if (con2_hit) begin
        pf_ctrl.pf2pri <= bus_q.data[denise_pkg::CON2_PF2PRI_BIT];
      end
    end
  end

  // BPL7DAT and BPL8DAT are never targeted by the bus master
  a_bpl_plane_range : assert property (@(posedge clk) disable iff (!rst_n)
    bpl_wr.valid |-> (bpl_wr.plane < 3'(denise_pkg::NUM_PLANES)));

endmodule

/* run.sh */
#!/bin/sh
# Build the playfield video path testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_denise -f src.f -o tb_denise
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_denise 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The testbench prints the pass line only when every check matched
if printf '%s\n' "$out" | grep -qx "Verification passed"; then
  exit 0
fi
echo "Pass line not found in the simulation output"
exit 1

/* src.f */
rtl/denise_pkg.sv
rtl/reg_decoder.sv
rtl/bitplane_shifter.sv
rtl/playfield_priority.sv
rtl/colour_table.sv
rtl/pixel_output.sv
rtl/denise_top.sv
tests/tb_clock.sv
tests/tb_denise.sv

/* tests/denise_input.txt */
# T <test name> | W <word address hex> <data hex> | E <pixel count> <rgb hex>
# E checks that many consecutive output pixels, one per clock, from the current one
T reset_state
E 1 000
W c0 0000
# 4 planes, planes 5 and 6 written but masked
T single_4_planes
W 80 4000
W c5 05a3
W ca 01c7
W cf 0e2d
W c1 0348
W 89 0ff0
W 8a f0f0
W 8b 0ff0
W 8c ffff
W 8d ffff
W 88 f0ff
E 4 5a3
E 4 1c7
E 4 e2d
E 4 348
# Runs: pf1 only, pf2 only, both, none
T dual_playfield
W 80 6400
W 82 0000
W c3 07b2
W cd 029f
W c6 0c41
W ca 0a5e
W 89 0f00
W 8a f0f0
W 8b 00f0
W 8c 00f0
W 8d 0f00
W 88 f000
E 4 7b2
E 4 29f
E 4 c41
E 4 000
# Same planes reloaded with playfield 2 in front
W 82 0040
W 88 f000
E 4 7b2
E 4 29f
E 4 a5e
E 4 000
T extra_half_brite
W 80 6000
W c7 0f93
W d2 06ae
W 89 ffff
W 8a ff00
W 8b 0000
W 8c 00ff
W 8d 0ff0
W 88 ff00
E 4 f93
E 4 741
E 4 357
E 4 6ae
# Select entry 4, then modify blue, red, green
T hold_and_modify
W 80 6800
W c4 03c5
W 89 0f00
W 8a f000
W 8b 0ff0
W 8c 0f0f
W 8d 00ff
W 88 00ff
E 4 3c5
E 4 3ca
E 4 9ca
E 4 91a
T after_load
W 80 1000
W c1 0348
W 88 8001
E 1 348
E 14 000
E 1 348
E 8 000

/* tests/tb_clock.sv */
//////////////////////////////////////////////////////////////////////
// Clock and reset for the testbench, 20 ns period
// Reset is released on the rising edge after 10 cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Release lines up with the rising edge, like any other input
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* tests/tb_denise.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for denise_top driven from tests/denise_input.txt
// Inputs change on the rising edge and rgb is sampled on the falling edge
// Colour entries must be written before a test displays them
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_denise;

  localparam int RESET_TIMEOUT = 100;

  logic                clk;
  logic                rst_n;
  denise_pkg::reg_wr_t bus;
  denise_pkg::rgb_t    rgb;

  // Bookkeeping
  string cur_test;
  int    test_errs;
  int    tests_run;
  int    tests_failed;
  int    total_errs;
  int    checks;
  int    burst_left;  // Pixels of the last plane 1 load still unchecked

  tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  denise_top dut0 (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus),
    .rgb   (rgb)
  );

  //////////////////////////////////////////////////////////////////////
  // Bus and cycle helpers
  //////////////////////////////////////////////////////////////////////

  // One idle bus cycle that ends mid-cycle
  task automatic step_cycle();
    @(posedge clk);
    bus <= '0;
    @(negedge clk);
  endtask

  // Write sits on the bus for exactly one sampling edge
  task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
    denise_pkg::reg_wr_t wr;
    wr.valid = 1'b1;
    wr.addr  = addr;
    wr.data  = data;
    @(posedge clk);
    bus <= wr;
    @(negedge clk);
  endtask

  // Sampling edge of the write plus the pipeline depth
  task automatic wait_latency();
    int cycles;
    cycles = 0;
    while (cycles < denise_pkg::PIXEL_LATENCY + 1) begin
      step_cycle();
      cycles++;
    end
  endtask

  task automatic wait_reset(output bit released);
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    released = (rst_n === 1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic compare_rgb(input denise_pkg::rgb_t got, input denise_pkg::rgb_t exp);
    checks++;
    if (got !== exp) begin
      $display("ERR %0t ns rgb got %03h expected %03h", $time, got, exp);
      test_errs++;
    end
  endtask

  task automatic report_fault(input string msg);
    $display("Test %s: %s", cur_test, msg);
    test_errs++;
  endtask

  // Each compare is followed by one cycle so the next pixel is on rgb
  task automatic check_pixels(input int count, input denise_pkg::rgb_t exp);
    for (int i = 0; i < count; i++) begin
      compare_rgb(rgb, exp);
      if (burst_left > 0) begin
        burst_left--;
      end
      step_cycle();
    end
  endtask

  task automatic close_test();
    if (burst_left != 0) begin
      report_fault($sformatf("%0d pixels of the last load were never checked", burst_left));
      burst_left = 0;
    end
    total_errs += test_errs;
    if (cur_test != "") begin
      tests_run++;
      if (test_errs == 0) begin
        $display("test %s ok", cur_test);
      end else begin
        tests_failed++;
        $display("test %s FAILED with %0d errors", cur_test, test_errs);
      end
    end
    test_errs = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Input file
  //////////////////////////////////////////////////////////////////////

  task automatic run_file();
    int          fd;
    int          n;
    int          count;
    string       line;
    string       kind;
    string       name;
    logic [31:0] v1;
    logic [31:0] v2;
    fd = $fopen("tests/denise_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the input file tests/denise_input.txt");
      total_errs++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s", kind);
        // Blank lines and comments
        if (n < 1 || kind.substr(0, 0) == "#") begin
          continue;
        end
        if (kind == "T") begin
          close_test();
          n = $sscanf(line, "%s %s", kind, name);
          cur_test = (n == 2) ? name : "unnamed";
        end else if (kind == "W") begin
          n = $sscanf(line, "%s %h %h", kind, v1, v2);
          if (n != 3) begin
            report_fault("write line without address and data");
          end else if (burst_left != 0) begin
            report_fault("write came before the last load was fully checked");
            burst_left = 0;
          end else begin
            bus_write(v1[7:0], v2[15:0]);
            // A plane 1 write starts 16 pixels
            if (v1[7:0] == denise_pkg::BPL1DAT_ADDR) begin
              wait_latency();
              burst_left = denise_pkg::PLANE_W;
            end
          end
        end else if (kind == "E") begin
          n = $sscanf(line, "%s %d %h", kind, count, v1);
          if (n != 3 || count < 1) begin
            report_fault("expect line without pixel count and colour");
          end else begin
            check_pixels(count, v1[11:0]);
          end
        end else begin
          report_fault($sformatf("unknown line kind %s", kind));
        end
      end
      close_test();
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    bit released;
    bus          = '0;
    cur_test     = "";
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    total_errs   = 0;
    checks       = 0;
    burst_left   = 0;
    // Ends on the falling edge right after release
    wait_reset(released);
    if (!released) begin
      $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
      $display("Verification failed");
      $finish;
    end else begin
      run_file();
      $display("%0d tests, %0d failed, %0d pixel checks, %0d errors",
               tests_run, tests_failed, checks, total_errs);
      if (total_errs == 0 && tests_run > 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

endmodule
